// ==== src/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    localparam int data_w = 8;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_INC = 3'd2,
        OP_DEC = 3'd3,
        OP_NEG = 3'd4,
        OP_CMP = 3'd5
    } alu_op_e;

    // sideband that rides through the adder
    typedef struct packed {
        alu_op_e             op;
        logic [data_w-1:0]   a_orig;   // cmp returns this
    } alu_tag_s;

    typedef struct packed {
        logic [data_w-1:0]   x;
        logic [data_w-1:0]   y;
        logic                cin;
        alu_tag_s            tag;
    } add_req_s;

    typedef struct packed {
        logic [data_w-1:0]   sum;
        logic                cout;
        logic                x_msb;
        logic                y_msb;
        alu_tag_s            tag;
    } add_rsp_s;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
        logic v;
    } alu_flags_s;

endpackage

`default_nettype wire

// ==== src/alu_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_decode (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         in_valid,
    input  alu_pkg::alu_op_e                  op,
    input  wire logic [alu_pkg::data_w-1:0]   a,
    input  wire logic [alu_pkg::data_w-1:0]   b,
    output logic                              dec_valid,
    output alu_pkg::add_req_s                 dec_req
);

    import alu_pkg::*;

    logic [data_w-1:0] x_next;
    logic [data_w-1:0] y_next;
    logic              cin_next;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode to adder operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        x_next   = a;
        y_next   = b;
        cin_next = 1'b0;
        case (op)
            OP_ADD: begin
                y_next = b;
            end
            OP_SUB, OP_CMP: begin
                y_next   = ~b;       // a + ~b + 1
                cin_next = 1'b1;
            end
            OP_INC: begin
                y_next   = '0;
                cin_next = 1'b1;
            end
            OP_DEC: begin
                y_next = '1;         // a + all ones
            end
            OP_NEG: begin
                x_next   = '0;
                y_next   = ~a;
                cin_next = 1'b1;
            end
            default: begin
                // unused encodings fall back to add
                y_next = b;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec_req   <= '0;
        end else begin
            dec_valid          <= in_valid;
            dec_req.x          <= x_next;
            dec_req.y          <= y_next;
            dec_req.cin        <= cin_next;
            dec_req.tag.op     <= op;
            dec_req.tag.a_orig <= a;
        end
    end

endmodule

`default_nettype wire

// ==== src/carry_chain_adder.sv ====
`timescale 1ns/1ps
`default_nettype none

module carry_chain_adder (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  wire logic          in_valid,
    input  alu_pkg::add_req_s  req,
    output logic               out_valid,
    output alu_pkg::add_rsp_s  rsp
);

    import alu_pkg::*;

    localparam int half_w = data_w / 2;

    // one record per pipeline stage, carries fill in as it goes
    typedef struct packed {
        logic [data_w-1:0] g;
        logic [data_w-1:0] p;
        logic [data_w:0]   c;      // c[i] is carry into bit i
        logic              x_msb;
        logic              y_msb;
        alu_tag_s          tag;
    } chain_stage_s;

    chain_stage_s s1;
    chain_stage_s s2;
    chain_stage_s s3;
    logic         s1_valid;
    logic         s2_valid;
    logic         s3_valid;

    // manchester chain over one half, returns carries out of each bit
    function automatic logic [half_w-1:0] chain_half(
        input logic [half_w-1:0] g,
        input logic [half_w-1:0] p,
        input logic              c_in
    );
        logic              carry;
        logic [half_w-1:0] c_out;
        carry = c_in;
        for (int i = 0; i < half_w; i++) begin
            carry    = g[i] | (p[i] & carry);
            c_out[i] = carry;
        end
        return c_out;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1: generate / propagate
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
            s1       <= '0;
        end else begin
            s1_valid <= in_valid;
            s1.g     <= req.x & req.y;
            s1.p     <= req.x ^ req.y;
            s1.c     <= {{data_w{1'b0}}, req.cin};
            s1.x_msb <= req.x[data_w-1];
            s1.y_msb <= req.y[data_w-1];
            s1.tag   <= req.tag;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 2: low half of the chain
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
            s2       <= '0;
        end else begin
            s2_valid          <= s1_valid;
            s2                <= s1;
            s2.c[half_w:1]    <= chain_half(s1.g[half_w-1:0], s1.p[half_w-1:0], s1.c[0]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 3: high half, top carry is cout
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s3_valid <= 1'b0;
            s3       <= '0;
        end else begin
            s3_valid                 <= s2_valid;
            s3                       <= s2;
            s3.c[data_w:half_w+1]    <= chain_half(s2.g[data_w-1:half_w],
                                                   s2.p[data_w-1:half_w],
                                                   s2.c[half_w]);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 4: sum
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            out_valid <= s3_valid;
            rsp.sum   <= s3.p ^ s3.c[data_w-1:0];
            rsp.cout  <= s3.c[data_w];
            rsp.x_msb <= s3.x_msb;   // kept for overflow
            rsp.y_msb <= s3.y_msb;
            rsp.tag   <= s3.tag;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_result (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        in_valid,
    input  alu_pkg::add_rsp_s                rsp,
    output logic                             out_valid,
    output logic [alu_pkg::data_w-1:0]       result,
    output alu_pkg::alu_flags_s              flags
);

    import alu_pkg::*;

    logic [data_w-1:0] result_next;
    alu_flags_s        flags_next;
    logic              sum_msb;

    assign sum_msb = rsp.sum[data_w-1];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result select and flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        if (rsp.tag.op == OP_CMP) begin
            result_next = rsp.tag.a_orig;   // compare leaves a untouched
        end else begin
            result_next = rsp.sum;
        end
    end

    always_comb begin
        flags_next.c = rsp.cout;            // no borrow on sub / cmp
        flags_next.z = (rsp.sum == '0);
        flags_next.n = sum_msb;
        // same sign in, different sign out
        flags_next.v = (rsp.x_msb == rsp.y_msb) && (sum_msb != rsp.x_msb);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
            flags     <= '0;
        end else begin
            out_valid <= in_valid;
            result    <= result_next;
            flags     <= flags_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/alu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         in_valid,
    input  alu_pkg::alu_op_e                  op,
    input  wire logic [alu_pkg::data_w-1:0]   a,
    input  wire logic [alu_pkg::data_w-1:0]   b,
    output logic                              out_valid,
    output logic [alu_pkg::data_w-1:0]        result,
    output alu_pkg::alu_flags_s               flags
);

    import alu_pkg::*;

    logic      dec_valid;
    add_req_s  dec_req;
    logic      add_valid;
    add_rsp_s  add_rsp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode -> adder -> result, 6 cycles end to end
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    alu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .dec_valid (dec_valid),
        .dec_req   (dec_req)
    );

    carry_chain_adder u_adder (   // 4 stages
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (dec_valid),
        .req       (dec_req),
        .out_valid (add_valid),
        .rsp       (add_rsp)
    );

    alu_result u_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (add_valid),
        .rsp       (add_rsp),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

endmodule

`default_nettype wire

// ==== tb/alu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_tb;

    import alu_pkg::*;

    // one line of the stimulus file
    typedef struct packed {
        logic [2:0]        op;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] result;
        logic [3:0]        flags;
    } stim_s;

    typedef struct packed {
        int unsigned idx;
        int unsigned issue_cycle;
    } pending_s;

    localparam int unsigned latency = 6;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    alu_op_e           op;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic              out_valid;
    logic [data_w-1:0] result;
    alu_flags_s        flags;

    stim_s       stim[$];
    string       names[$];
    pending_s    pending_q[$];     // issued, not yet seen at the output
    int unsigned cycle_count    = 0;
    int unsigned timeout_limit  = 0;
    int unsigned check_count    = 0;
    int unsigned mismatch_count = 0;
    int unsigned other_count    = 0;
    logic [31:0] rng_state      = 32'he09ae635;

    alu_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            mismatch_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        string       name;
        logic [31:0] f_op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_res;
        logic [31:0] f_flags;
        stim_s       rec;
        fd = $fopen("tb/alu_stimulus.txt", "r");
        if (fd == 0) begin
            other_count++;
            $display("ERROR: cannot open tb/alu_stimulus.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;   // blank or comment
                end
                code = $sscanf(line, "%s %h %h %h %h %h",
                               name, f_op, f_a, f_b, f_res, f_flags);
                if (code != 6) begin
                    other_count++;
                    $display("ERROR: malformed stimulus line: %s", line);
                end else begin
                    rec.op     = f_op[2:0];
                    rec.a      = f_a[data_w-1:0];
                    rec.b      = f_b[data_w-1:0];
                    rec.result = f_res[data_w-1:0];
                    rec.flags  = f_flags[3:0];
                    stim.push_back(rec);
                    names.push_back(name);
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic issue_item(input int unsigned idx);
        pending_s p;
        in_valid      = 1'b1;
        op            = alu_op_e'(stim[idx].op);
        a             = stim[idx].a;
        b             = stim[idx].b;
        if (op == OP_INC || op == OP_DEC || op == OP_NEG) begin
            rng_state = xorshift32(rng_state);
            b         = rng_state[data_w-1:0];   // unary ops ignore b
        end
        p.idx         = idx;
        p.issue_cycle = cycle_count;
        pending_q.push_back(p);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitor and cycle counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        pending_s p;
        if (out_valid === 1'b1) begin
            if (pending_q.size() == 0) begin
                other_count++;
                $display("ERROR: out_valid high at cycle %0d with nothing outstanding",
                         cycle_count);
            end else begin
                p = pending_q.pop_front();
                check_value({names[p.idx], " result"}, {24'd0, stim[p.idx].result},
                            {24'd0, result});
                check_value({names[p.idx], " flags"}, {28'd0, stim[p.idx].flags},
                            {28'd0, flags});
                check_value({names[p.idx], " latency"}, latency,
                            cycle_count - p.issue_cycle);
            end
        end else if (rst_n === 1'b1 && out_valid !== 1'b0) begin
            other_count++;
            $display("ERROR: out_valid unknown at cycle %0d", cycle_count);
        end
        cycle_count++;
        if (timeout_limit != 0 && cycle_count > timeout_limit) begin
            $display("ERROR: timeout after %0d cycles, %0d operations outstanding",
                     cycle_count, pending_q.size());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int unsigned n_items;
        int unsigned gap;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        op       = OP_ADD;
        a        = '0;
        b        = '0;
        load_stimulus();
        n_items = stim.size();
        if (n_items == 0) begin
            $display("ERROR: no stimulus items loaded");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            timeout_limit = 2 * n_items + 40;

            repeat (4) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            check_value("reset result", 32'd0, {24'd0, result});
            check_value("reset flags", 32'd0, {28'd0, flags});
            check_value("reset out_valid", 32'd0, {31'd0, out_valid});

            repeat (3) @(negedge clk);   // idle so the monitor sees any stray out_valid

            // back to back for the first half then random gaps
            for (int unsigned i = 0; i < n_items; i++) begin
                issue_item(i);
                @(negedge clk);
                in_valid = 1'b0;
                if (i >= n_items / 2) begin
                    rng_state = xorshift32(rng_state);
                    gap       = rng_state % 3;
                    repeat (gap) @(negedge clk);
                end
            end

            while (pending_q.size() != 0) @(posedge clk);
            repeat (4) @(negedge clk);   // late duplicates would show here

            $display("checks %0d, value mismatches %0d, other errors %0d",
                     check_count, mismatch_count, other_count);
            if (mismatch_count == 0 && other_count == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/alu_stimulus.txt ====
# columns: name op a b result flags, all values hex
# op 0 add 1 sub 2 inc 3 dec 4 neg 5 cmp, flags = {c z n v}
# add
add_zero   0 00 00 00 4
add_ff_01  0 ff 01 00 c
add_7f_01  0 7f 01 80 3
add_80_80  0 80 80 00 d
add_12_34  0 12 34 46 0
add_ff_ff  0 ff ff fe a
add_40_40  0 40 40 80 3
add_c0_c0  0 c0 c0 80 a
add_a5_5a  0 a5 5a ff 2
add_81_7f  0 81 7f 00 c
add_01_fe  0 01 fe ff 2
# sub
sub_05_03  1 05 03 02 8
sub_03_05  1 03 05 fe 2
sub_00_01  1 00 01 ff 2
sub_80_01  1 80 01 7f 9
sub_7f_ff  1 7f ff 80 3
sub_44_44  1 44 44 00 c
sub_ff_ff  1 ff ff 00 c
sub_00_00  1 00 00 00 c
sub_80_7f  1 80 7f 01 9
sub_10_20  1 10 20 f0 2
sub_c8_37  1 c8 37 91 a
# cmp returns a
cmp_05_03  5 05 03 05 8
cmp_03_05  5 03 05 03 2
cmp_22_22  5 22 22 22 c
cmp_80_01  5 80 01 80 9
cmp_7f_ff  5 7f ff 7f 3
cmp_00_00  5 00 00 00 c
cmp_ff_00  5 ff 00 ff a
cmp_01_80  5 01 80 01 3
# inc
inc_00     2 00 00 01 0
inc_7f     2 7f 00 80 3
inc_ff     2 ff 00 00 c
inc_80     2 80 00 81 2
inc_3c     2 3c 00 3d 0
# dec
dec_00     3 00 00 ff 2
dec_01     3 01 00 00 c
dec_80     3 80 00 7f 9
dec_ff     3 ff 00 fe a
dec_5a     3 5a 00 59 8
# neg
neg_00     4 00 00 00 c
neg_80     4 80 00 80 3
neg_01     4 01 00 ff 2
neg_ff     4 ff 00 01 0
neg_7f     4 7f 00 81 2
neg_81     4 81 00 7f 0
# mixed
add_3c_c4  0 3c c4 00 c
sub_01_02  1 01 02 ff 2
add_55_2b  0 55 2b 80 3
cmp_90_10  5 90 10 90 a
inc_fe     2 fe 00 ff 2
dec_02     3 02 00 01 8
neg_40     4 40 00 c0 2
add_01_01  0 01 01 02 0

// ==== list.f ====
src/alu_pkg.sv
src/alu_decode.sv
src/carry_chain_adder.sv
src/alu_result.sv
src/alu_top.sv
tb/alu_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := alu_tb
FILE_LIST  := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

# the testbench opens its stimulus file relative to the project root
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
